// File: build.f
+incdir+design
design/trig_loop_pkg.sv
design/trig_bus_pkg.sv
design/count_window_timer.sv
design/beam_trigger_bank.sv
design/threshold_servo.sv
design/l1_trigger_top.sv
verification/tb_l1_trigger.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_l1_trigger
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "simulation ended without reaching the end of the test"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_l1_trigger.sv
`include "trig_loop_macros.svh"

module tb_l1_trigger import trig_loop_pkg::*; ();

    // roughly ten loop passes of about 150 cycles each plus readback
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RUN_PASSES     = 6;
    localparam longint THR_MAX    = (longint'(1) << `THRESH_W) - 1;
    // manual test beam and a threshold above its power
    localparam int MAN_BEAM                 = 2;
    localparam logic [`THRESH_W-1:0] MAN_THRESH = 18'h3f000;

    logic                          wb_clk = 1'b0;
    logic                          rst_n;
    logic                          loop_enable;
    logic                          reset_complete;
    loop_state_t                   loop_state_req;
    loop_state_t                   loop_state;
    logic [`DAT_W-1:0]             target_rate;
    logic [15:0]                   target_delta;
    logic [`DAT_W-1:0]             thresh_dat_in;
    logic [`BEAM_IDX_W-1:0]        thresh_idx;
    logic                          thresh_upd;
    logic                          thresh_wr;
    logic                          thresh_ack;
    logic [`THRESH_W-1:0]          thresh_dat;
    logic [`BEAM_IDX_W-1:0]        scal_idx;
    logic [`DAT_W-1:0]             scal_dat;
    logic [`NBEAMS*`THRESH_W-1:0]  beam_pwr;

    // reference thresholds as the bank holds them after apply
    logic [`THRESH_W-1:0]          ref_thr [`NBEAMS];
    integer                        seed;
    int                            cycle_cnt = 0;

    l1_trigger_top u_dut (
        .wb_clk_i         (wb_clk),
        .rst_n_i          (rst_n),
        .loop_enable_i    (loop_enable),
        .reset_complete_o (reset_complete),
        .loop_state_req_i (loop_state_req),
        .loop_state_o     (loop_state),
        .target_rate_i    (target_rate),
        .target_delta_i   (target_delta),
        .thresh_dat_i     (thresh_dat_in),
        .thresh_idx_i     (thresh_idx),
        .thresh_upd_i     (thresh_upd),
        .thresh_wr_i      (thresh_wr),
        .thresh_ack_o     (thresh_ack),
        .thresh_dat_o     (thresh_dat),
        .scal_idx_i       (scal_idx),
        .scal_dat_o       (scal_dat),
        .beam_pwr_i       (beam_pwr)
    );

    always #20 wb_clk = ~wb_clk;

    always @(posedge wb_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the loop did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    // even beams far above any threshold the loop reaches and odd beams silent
    function automatic logic [`THRESH_W-1:0] beam_power(input int b);
        return (b % 2 == 0) ? `THRESH_W'(32'h30000 + b * 16) : '0;
    endfunction

    // full window when power beats the active threshold
    function automatic logic [`DAT_W-1:0] expected_count(input int b);
        return (beam_power(b) > ref_thr[b]) ? `DAT_W'(`WINDOW_CYCLES) : '0;
    endfunction

    function automatic logic [`THRESH_W-1:0] servo_step(input longint thr, input longint count,
                                                        input longint rate, input longint delta);
        longint lim;
        longint nxt;
        lim = rate + `COUNT_MARGIN;
        if (count < lim) begin
            nxt = thr - delta;
        end else if (count > lim) begin
            nxt = thr + delta;
        end else begin
            nxt = thr;
        end
        if (nxt < 0) begin
            nxt = 0;
        end
        if (nxt > THR_MAX) begin
            nxt = THR_MAX;
        end
        return `THRESH_W'(nxt);
    endfunction

    task automatic wait_for_mode(input loop_state_t want);
        @(posedge wb_clk);
        while (loop_state != want) @(posedge wb_clk);
    endtask

    task automatic wait_for_complete();
        @(posedge wb_clk);
        while (!reset_complete) @(posedge wb_clk);
    endtask

    // one pass with the request dropped back to stop as soon as it is taken
    task automatic run_pass(input loop_state_t mode);
        loop_state_req <= mode;
        wait_for_mode(mode);
        loop_state_req <= LOOP_STOP;
        wait_for_mode(LOOP_STOP);
    endtask

    task automatic manual_request(input logic wr, input int idx, input logic [`DAT_W-1:0] dat);
        thresh_idx    <= `BEAM_IDX_W'(idx);
        thresh_dat_in <= dat;
        thresh_wr     <= wr;
        thresh_upd    <= !wr;
        @(posedge wb_clk);
        while (!thresh_ack) @(posedge wb_clk);
        thresh_wr  <= 1'b0;
        thresh_upd <= 1'b0;
    endtask

    task automatic check_thresholds(input string phase);
        for (int b = 0; b < `NBEAMS; b++) begin
            thresh_idx <= `BEAM_IDX_W'(b);
            @(posedge wb_clk);
            assert (thresh_dat == ref_thr[b])
                else report_error($sformatf("%s: beam %0d threshold %0d, expected %0d",
                                            phase, b, thresh_dat, ref_thr[b]));
        end
    endtask

    task automatic check_scalers(input string phase);
        for (int b = 0; b < `NBEAMS; b++) begin
            scal_idx <= `BEAM_IDX_W'(b);
            @(posedge wb_clk);
            assert (scal_dat == expected_count(b))
                else report_error($sformatf("%s: beam %0d count %0d, expected %0d",
                                            phase, b, scal_dat, expected_count(b)));
        end
    endtask

    task automatic run_servo_pass(input int rate);
        logic [15:0] delta;
        delta = 16'h0400 + 16'($random(seed) & 32'h07ff);
        target_rate  <= `DAT_W'(rate);
        target_delta <= delta;
        run_pass(LOOP_RUN);
        check_scalers("run");
        for (int b = 0; b < `NBEAMS; b++) begin
            ref_thr[b] = servo_step(ref_thr[b], expected_count(b), rate, delta);
        end
        check_thresholds("run");
    endtask

    a_ack_single: assert property (@(posedge wb_clk) disable iff (!rst_n)
        thresh_ack |=> !thresh_ack)
        else report_error("thresh_ack_o stayed high for more than one cycle");

    a_ack_requested: assert property (@(posedge wb_clk) disable iff (!rst_n)
        $rose(thresh_ack) |-> $past(thresh_wr || thresh_upd))
        else report_error("thresh_ack_o rose without a manual request");

    a_mode_follows_req: assert property (@(posedge wb_clk) disable iff (!rst_n)
        !$stable(loop_state) |-> loop_state == $past(loop_state_req))
        else report_error("loop_state_o moved to a mode that was not requested");

    initial begin
        seed = 32'h039e_9438;
        rst_n          <= 1'b0;
        loop_enable    <= 1'b0;
        loop_state_req <= LOOP_RESET;
        target_rate    <= '0;
        target_delta   <= '0;
        thresh_dat_in  <= '0;
        thresh_idx     <= '0;
        thresh_upd     <= 1'b0;
        thresh_wr      <= 1'b0;
        scal_idx       <= '0;
        for (int b = 0; b < `NBEAMS; b++) begin
            beam_pwr[b*`THRESH_W +: `THRESH_W] <= beam_power(b);
            ref_thr[b] = `START_THRESH;
        end
        repeat (8) @(posedge wb_clk);
        rst_n <= 1'b1;
        @(posedge wb_clk);
        assert (!reset_complete && loop_state == LOOP_RESET && !thresh_ack)
            else report_error("outputs not inactive after reset");

        // reset sequence
        loop_enable <= 1'b1;
        wait_for_complete();
        check_thresholds("reset");
        loop_state_req <= LOOP_STOP;
        wait_for_mode(LOOP_STOP);
        assert (reset_complete) else report_error("reset_complete_o dropped in stop");

        // pause refreshes counts only
        run_pass(LOOP_PAUSE);
        check_scalers("pause");
        check_thresholds("pause");

        // rate 62 puts the even beams exactly on target plus margin
        for (int i = 0; i < RUN_PASSES; i++) begin
            run_servo_pass((i == 2) ? 62 : 30);
        end

        // manual write, readback, then apply
        manual_request(1'b1, MAN_BEAM, `DAT_W'(MAN_THRESH));
        ref_thr[MAN_BEAM] = MAN_THRESH;
        check_thresholds("manual write");
        manual_request(1'b0, MAN_BEAM, '0);
        run_pass(LOOP_PAUSE);
        check_scalers("manual pause");
        check_thresholds("manual pause");

        // a reset request drops completion and reloads the start threshold
        loop_state_req <= LOOP_RESET;
        wait_for_mode(LOOP_RESET);
        assert (!reset_complete) else report_error("reset_complete_o held after reset request");
        wait_for_complete();
        for (int b = 0; b < `NBEAMS; b++) begin
            ref_thr[b] = `START_THRESH;
        end
        check_thresholds("second reset");
        assert (loop_state == LOOP_RESET) else report_error("loop_state_o not reset");

        $display("Regression passed");
        $finish;
    end

endmodule

// File: design/l1_trigger_top.sv
`include "trig_loop_macros.svh"

module l1_trigger_top import trig_loop_pkg::*; (
    input  logic                          wb_clk_i,
    input  logic                          rst_n_i,
    input  logic                          loop_enable_i,
    output logic                          reset_complete_o,
    input  loop_state_t                   loop_state_req_i,
    output loop_state_t                   loop_state_o,
    input  logic [`DAT_W-1:0]             target_rate_i,
    input  logic [15:0]                   target_delta_i,
    input  logic [`DAT_W-1:0]             thresh_dat_i,
    input  logic [`BEAM_IDX_W-1:0]        thresh_idx_i,
    input  logic                          thresh_upd_i,
    input  logic                          thresh_wr_i,
    output logic                          thresh_ack_o,
    output logic [`THRESH_W-1:0]          thresh_dat_o,
    input  logic [`BEAM_IDX_W-1:0]        scal_idx_i,
    output logic [`DAT_W-1:0]             scal_dat_o,
    input  logic [`NBEAMS*`THRESH_W-1:0]  beam_pwr_i
);

    logic              loop_cyc;
    logic              loop_stb;
    logic              loop_we;
    logic [`ADR_W-1:0] loop_adr;
    logic [`DAT_W-1:0] loop_wdat;
    logic              loop_ack;
    logic [`DAT_W-1:0] loop_rdat;
    logic              win_start;
    logic              win_done;

    threshold_servo u_servo (
        .wb_clk_i         (wb_clk_i),
        .rst_n_i          (rst_n_i),
        .loop_enable_i    (loop_enable_i),
        .reset_complete_o (reset_complete_o),
        .loop_state_req_i (loop_state_req_i),
        .loop_state_o     (loop_state_o),
        .target_rate_i    (target_rate_i),
        .target_delta_i   (target_delta_i),
        .thresh_dat_i     (thresh_dat_i),
        .thresh_idx_i     (thresh_idx_i),
        .thresh_upd_i     (thresh_upd_i),
        .thresh_wr_i      (thresh_wr_i),
        .thresh_ack_o     (thresh_ack_o),
        .thresh_dat_o     (thresh_dat_o),
        .scal_idx_i       (scal_idx_i),
        .scal_dat_o       (scal_dat_o),
        .loop_cyc_o       (loop_cyc),
        .loop_stb_o       (loop_stb),
        .loop_we_o        (loop_we),
        .loop_adr_o       (loop_adr),
        .loop_dat_o       (loop_wdat),
        .loop_ack_i       (loop_ack),
        .loop_dat_i       (loop_rdat),
        .win_done_i       (win_done)
    );

    beam_trigger_bank u_bank (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .cyc_i       (loop_cyc),
        .stb_i       (loop_stb),
        .we_i        (loop_we),
        .adr_i       (loop_adr),
        .dat_i       (loop_wdat),
        .ack_o       (loop_ack),
        .dat_o       (loop_rdat),
        .beam_pwr_i  (beam_pwr_i),
        .win_start_o (win_start),
        .win_done_i  (win_done)
    );

    count_window_timer u_timer (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .win_start_i (win_start),
        .win_done_o  (win_done)
    );

endmodule

// File: design/threshold_servo.sv
`include "trig_loop_macros.svh"

module threshold_servo import trig_loop_pkg::*, trig_bus_pkg::*; (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  logic                    loop_enable_i,
    output logic                    reset_complete_o,
    input  loop_state_t             loop_state_req_i,
    output loop_state_t             loop_state_o,
    input  logic [`DAT_W-1:0]       target_rate_i,
    input  logic [15:0]             target_delta_i,
    input  logic [`DAT_W-1:0]       thresh_dat_i,
    input  logic [`BEAM_IDX_W-1:0]  thresh_idx_i,
    input  logic                    thresh_upd_i,
    input  logic                    thresh_wr_i,
    output logic                    thresh_ack_o,
    output logic [`THRESH_W-1:0]    thresh_dat_o,
    input  logic [`BEAM_IDX_W-1:0]  scal_idx_i,
    output logic [`DAT_W-1:0]       scal_dat_o,
    output logic                    loop_cyc_o,
    output logic                    loop_stb_o,
    output logic                    loop_we_o,
    output logic [`ADR_W-1:0]       loop_adr_o,
    output logic [`DAT_W-1:0]       loop_dat_o,
    input  logic                    loop_ack_i,
    input  logic [`DAT_W-1:0]       loop_dat_i,
    input  logic                    win_done_i
);

    servo_state_t            state;
    // counts down, the extra top bit flags the wrap past zero
    logic [`BEAM_IDX_W:0]    beam_idx;
    logic                    beams_done;
    logic [`BEAM_IDX_W-1:0]  cur_beam;
    logic [`BEAM_IDX_W-1:0]  man_idx;
    logic                    man_upd;
    logic [`THRESH_W-1:0]    thr_tmp;
    logic [`THRESH_W-1:0]    thr_next;
    logic [`THRESH_W:0]      thr_up;
    logic [`DAT_W:0]         rate_lim;
    logic [`THRESH_W-1:0]    thresh_mem [`NBEAMS];
    logic [`DAT_W-1:0]       scal_ram [`NBEAMS];

    function automatic logic [`ADR_W-1:0] bus_adr(reg_region_t r,
                                                   logic [`BEAM_IDX_W-1:0] b);
        logic [`ADR_W-1:0] a;
        a = '0;
        a[13:10] = r;
        a[2 +: `BEAM_IDX_W] = b;
        return a;
    endfunction

    assign beams_done = beam_idx[`BEAM_IDX_W];
    assign cur_beam   = (loop_state_o == LOOP_STOP) ? man_idx : beam_idx[`BEAM_IDX_W-1:0];

    // master strobes only in the transfer states
    assign loop_cyc_o = state inside {S_COUNT_START, S_COUNT_READ, S_THRESH_WRITE,
                                      S_CE_WRITE, S_APPLY};
    assign loop_stb_o = loop_cyc_o;
    assign loop_we_o  = loop_cyc_o && (state != S_COUNT_READ);

    assign thresh_ack_o = (state == S_STOP_PREP);
    assign thresh_dat_o = thresh_mem[thresh_idx_i];
    assign scal_dat_o   = scal_ram[scal_idx_i];

    // rate servo step with clamping
    assign rate_lim = {1'b0, target_rate_i} + (`DAT_W+1)'(`COUNT_MARGIN);
    assign thr_up   = {1'b0, thr_tmp} + target_delta_i;

    always_comb begin
        if ({1'b0, loop_dat_i} < rate_lim) begin
            thr_next = (thr_tmp < target_delta_i) ? '0 : thr_tmp - target_delta_i;
        end else if ({1'b0, loop_dat_i} > rate_lim) begin
            thr_next = thr_up[`THRESH_W] ? '1 : thr_up[`THRESH_W-1:0];
        end else begin
            thr_next = thr_tmp;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state            <= S_RESET_START;
            loop_state_o     <= LOOP_RESET;
            reset_complete_o <= 1'b0;
            beam_idx         <= (`BEAM_IDX_W+1)'(`NBEAMS - 1);
        end else begin
            if (state == S_IDLE) begin
                loop_state_o <= loop_state_req_i;
            end

            if (state == S_RESET_DONE) begin
                reset_complete_o <= 1'b1;
            end else if (loop_state_req_i == LOOP_RESET) begin
                reset_complete_o <= 1'b0;
            end

            case (state)
                S_RESET_START: if (loop_enable_i) state <= S_RESETTING;
                S_RESETTING:   if (beams_done) state <= S_RESET_PREP;
                S_RESET_PREP:  state <= S_THRESH_WRITE;
                S_RESET_DONE:  if (loop_state_req_i != LOOP_RESET) state <= S_IDLE;
                S_IDLE: begin
                    // leave idle only once the latched mode matches the request
                    if (loop_state_req_i == loop_state_o) begin
                        case (loop_state_o)
                            LOOP_RESET: state <= S_RESET_START;
                            LOOP_STOP:  if (thresh_upd_i || thresh_wr_i) state <= S_STOP_PREP;
                            default:    state <= S_COUNT_START;
                        endcase
                    end
                end
                S_COUNT_START: if (loop_ack_i) state <= S_COUNT_WAIT;
                S_COUNT_WAIT:  if (win_done_i) state <= S_COUNT_READ;
                S_COUNT_READ: begin
                    if (loop_ack_i) begin
                        state <= (loop_state_o == LOOP_RUN) ? S_CALC : S_COUNT_NEXT;
                    end
                end
                S_CALC: state <= S_COUNT_NEXT;
                S_COUNT_NEXT: begin
                    if (!beams_done) begin
                        state <= S_COUNT_READ;
                    end else begin
                        state <= (loop_state_o == LOOP_PAUSE) ? S_IDLE : S_THRESH_NEXT;
                    end
                end
                S_THRESH_WRITE: if (loop_ack_i) state <= S_THRESH_WAIT;
                S_THRESH_WAIT:  state <= S_CE_WRITE;
                S_CE_WRITE: begin
                    if (loop_ack_i) begin
                        state <= (loop_state_o == LOOP_STOP) ? S_IDLE : S_THRESH_NEXT;
                    end
                end
                S_THRESH_NEXT: state <= beams_done ? S_APPLY : S_THRESH_WRITE;
                S_APPLY: begin
                    if (loop_ack_i) begin
                        state <= (loop_state_o == LOOP_RESET) ? S_RESET_DONE : S_IDLE;
                    end
                end
                S_STOP_PREP: state <= man_upd ? S_APPLY : S_THRESH_WRITE;
                default: state <= S_IDLE;
            endcase

            if (state == S_RESET_START || state == S_IDLE || beams_done) begin
                beam_idx <= (`BEAM_IDX_W+1)'(`NBEAMS - 1);
            end else if (state == S_RESETTING || state == S_CALC ||
                         (state == S_CE_WRITE && loop_ack_i) ||
                         (state == S_COUNT_READ && loop_ack_i && loop_state_o != LOOP_RUN)) begin
                beam_idx <= beam_idx - 1'b1;
            end
        end
    end

    // address, data and memories
    always_ff @(posedge wb_clk_i) begin
        if (state == S_IDLE) begin
            loop_adr_o <= bus_adr(REG_CTRL, '0);
        end else if (state inside {S_COUNT_WAIT, S_COUNT_NEXT, S_RESET_PREP} ||
                     (state == S_THRESH_NEXT && !beams_done) ||
                     (state == S_STOP_PREP && !man_upd)) begin
            loop_adr_o <= bus_adr(REG_THRESH, cur_beam);
        end else if (state == S_THRESH_WAIT) begin
            loop_adr_o <= bus_adr(REG_CE, cur_beam);
        end else if (state == S_THRESH_NEXT || state == S_STOP_PREP) begin
            loop_adr_o <= bus_adr(REG_CTRL, '0);
        end

        if (state == S_IDLE) begin
            loop_dat_o <= CMD_START;
        end else if (state == S_THRESH_WAIT) begin
            // clock-enable mark
            loop_dat_o <= `DAT_W'd1;
        end else if ((state == S_THRESH_NEXT && beams_done) ||
                     (state == S_STOP_PREP && man_upd)) begin
            loop_dat_o <= CMD_APPLY;
        end else if (state == S_STOP_PREP) begin
            loop_dat_o <= `DAT_W'(thr_tmp);
        end else if (state == S_RESET_PREP || state == S_THRESH_NEXT) begin
            loop_dat_o <= `DAT_W'(thresh_mem[cur_beam]);
        end

        if (state == S_RESET_START) begin
            thr_tmp <= `START_THRESH;
        end else if (state == S_COUNT_READ) begin
            thr_tmp <= loop_ack_i ? thr_next : thresh_mem[beam_idx[`BEAM_IDX_W-1:0]];
        end else if (state == S_IDLE && thresh_wr_i) begin
            thr_tmp <= thresh_dat_i[`THRESH_W-1:0];
        end

        // manual request held from idle
        if (state == S_IDLE) begin
            man_upd <= thresh_upd_i;
            man_idx <= thresh_idx_i;
        end

        if (state == S_RESETTING || state == S_CALC || (state == S_STOP_PREP && !man_upd)) begin
            thresh_mem[cur_beam] <= thr_tmp;
        end

        if (state == S_COUNT_READ && loop_ack_i) begin
            scal_ram[beam_idx[`BEAM_IDX_W-1:0]] <= loop_dat_i;
        end
    end

    a_bus_hold: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        loop_stb_o && !loop_ack_i |=> loop_stb_o && $stable(loop_adr_o))
        else $error("strobe or address changed before acknowledge");

    a_mode_in_idle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        !$stable(loop_state_o) |-> $past(state == S_IDLE))
        else $error("loop state changed outside idle");

endmodule

// File: design/beam_trigger_bank.sv
`include "trig_loop_macros.svh"

module beam_trigger_bank import trig_bus_pkg::*; (
    input  logic                           wb_clk_i,
    input  logic                           rst_n_i,
    input  logic                           cyc_i,
    input  logic                           stb_i,
    input  logic                           we_i,
    input  logic [`ADR_W-1:0]              adr_i,
    input  logic [`DAT_W-1:0]              dat_i,
    output logic                           ack_o,
    output logic [`DAT_W-1:0]              dat_o,
    input  logic [`NBEAMS*`THRESH_W-1:0]   beam_pwr_i,
    output logic                           win_start_o,
    input  logic                           win_done_i
);

    reg_region_t             region;
    logic [`BEAM_IDX_W-1:0]  beam;
    logic                    wr;
    logic                    apply;
    logic                    win_open;
    logic [`NBEAMS-1:0]      ce_mark;
    logic [`THRESH_W-1:0]    staged [`NBEAMS];
    logic [`THRESH_W-1:0]    active [`NBEAMS];
    logic [`DAT_W-1:0]       hit_cnt [`NBEAMS];

    assign region = reg_region_t'(adr_i[13:10]);
    assign beam   = adr_i[2 +: `BEAM_IDX_W];

    // writes take effect in the acknowledge cycle
    assign wr          = cyc_i && stb_i && ack_o && we_i;
    assign win_start_o = wr && (region == REG_CTRL) && (dat_i == CMD_START);
    assign apply       = wr && (region == REG_CTRL) && (dat_i == CMD_APPLY);

    // count readback, other regions read as zero
    assign dat_o = (region == REG_THRESH) ? hit_cnt[beam] : '0;

    // fixed one-cycle wait state
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= cyc_i && stb_i && !ack_o;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wr && (region == REG_THRESH)) begin
            staged[beam] <= dat_i[`THRESH_W-1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ce_mark  <= '0;
            win_open <= 1'b0;
            for (int i = 0; i < `NBEAMS; i++) begin
                active[i] <= '0;
            end
        end else begin
            if (apply) begin
                // marked beams go live together
                for (int i = 0; i < `NBEAMS; i++) begin
                    if (ce_mark[i]) begin
                        active[i] <= staged[i];
                    end
                end
                ce_mark <= '0;
            end else if (wr && (region == REG_CE) && dat_i[0]) begin
                ce_mark[beam] <= 1'b1;
            end

            if (win_start_o) begin
                win_open <= 1'b1;
            end else if (win_done_i) begin
                win_open <= 1'b0;
            end
        end
    end

    // hit counters, saturating
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i || win_start_o) begin
            for (int i = 0; i < `NBEAMS; i++) begin
                hit_cnt[i] <= '0;
            end
        end else if (win_open && !win_done_i) begin
            for (int i = 0; i < `NBEAMS; i++) begin
                if ((beam_pwr_i[i*`THRESH_W +: `THRESH_W] > active[i]) &&
                    (hit_cnt[i] != '1)) begin
                    hit_cnt[i] <= hit_cnt[i] + 1'b1;
                end
            end
        end
    end

    a_ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        ack_o |-> stb_i)
        else $error("bank acknowledge without strobe");

endmodule

// File: design/count_window_timer.sv
`include "trig_loop_macros.svh"

module count_window_timer (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    input  logic win_start_i,
    output logic win_done_o
);

    logic [$clog2(`WINDOW_CYCLES)-1:0] cnt;
    logic busy;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            busy       <= 1'b0;
            win_done_o <= 1'b0;
        end else begin
            win_done_o <= 1'b0;
            if (win_start_i) begin
                busy <= 1'b1;
                cnt  <= $bits(cnt)'(`WINDOW_CYCLES - 1);
            end else if (busy) begin
                if (cnt == '0) begin
                    // last open cycle, done follows it
                    busy       <= 1'b0;
                    win_done_o <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // only one window may run at a time
    a_no_restart: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        win_start_i |-> !busy)
        else $error("window started while previous window still running");

endmodule

// File: design/trig_bus_pkg.sv
`include "trig_loop_macros.svh"

package trig_bus_pkg;

    // region select, address bits 13:10
    typedef enum logic [3:0] {
        REG_CTRL   = 4'h0,
        REG_THRESH = 4'h4,
        REG_CE     = 4'h8
    } reg_region_t;

    // commands written to the control region
    typedef enum logic [`DAT_W-1:0] {
        CMD_START = `DAT_W'd1,
        CMD_APPLY = `DAT_W'd2
    } ctrl_cmd_t;

endpackage

// File: design/trig_loop_pkg.sv
package trig_loop_pkg;

    // requested and current loop mode
    typedef enum logic [1:0] {
        LOOP_RESET = 2'd0,
        LOOP_RUN   = 2'd1,
        LOOP_STOP  = 2'd2,
        LOOP_PAUSE = 2'd3
    } loop_state_t;

    // servo sequencer, mode changes are taken only in S_IDLE
    typedef enum logic [3:0] {
        S_RESET_START,
        S_RESETTING,
        S_RESET_PREP,
        S_RESET_DONE,
        S_IDLE,
        S_COUNT_START,
        S_COUNT_WAIT,
        S_COUNT_READ,
        S_CALC,
        S_COUNT_NEXT,
        S_THRESH_WRITE,
        S_THRESH_WAIT,
        S_CE_WRITE,
        S_THRESH_NEXT,
        S_APPLY,
        S_STOP_PREP
    } servo_state_t;

endpackage

// File: design/trig_loop_macros.svh
`ifndef TRIG_LOOP_MACROS_SVH
`define TRIG_LOOP_MACROS_SVH

// beam geometry
`define NBEAMS        8
`define BEAM_IDX_W    3

// threshold and beam power width
`define THRESH_W      18
`define START_THRESH  18'd4500

// servo tuning
`define COUNT_MARGIN  2
`define WINDOW_CYCLES 64

// servo bus
`define ADR_W         22
`define DAT_W         32

`endif
